// ==== verilog/tlul_pkg.sv ====
package tlul_pkg;

  // A channel opcodes, reduced TL-UL set
  typedef enum logic [2:0] {
    PutFullData = 3'h0,
    Get         = 3'h4
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // host to device: A channel plus the D ready
  typedef struct packed {
    logic        a_valid;
    tl_a_op_e    a_opcode;
    logic [31:0] a_addr;
    logic [31:0] a_data;
    logic [3:0]  a_mask;
    logic        d_ready;
  } tl_h2d_t;

  // device to host: A ready plus the D channel
  typedef struct packed {
    logic        a_ready;
    logic        d_valid;
    tl_d_op_e    d_opcode;
    logic [31:0] d_data;
    logic        d_error;
  } tl_d2h_t;

  // peripheral windows, 64 KiB each
  localparam logic [31:0] GPIO_BASE  = 32'h4000_0000;
  localparam logic [31:0] TIMER_BASE = 32'h4001_0000;
  localparam logic [31:0] PWM_BASE   = 32'h4002_0000;
  localparam logic [31:0] DEV_MASK   = 32'hFFFF_0000;

  // register offset bits decoded inside a device
  localparam int unsigned REG_AW = 8;

  // gpio registers
  localparam logic [REG_AW-1:0] GPIO_DATA_IN     = 8'h00;
  localparam logic [REG_AW-1:0] GPIO_DATA_OUT    = 8'h04;
  localparam logic [REG_AW-1:0] GPIO_DIR         = 8'h08;
  localparam logic [REG_AW-1:0] GPIO_INTR_STATE  = 8'h0C;
  localparam logic [REG_AW-1:0] GPIO_INTR_ENABLE = 8'h10;

  // timer registers
  localparam logic [REG_AW-1:0] TMR_CTRL       = 8'h00;
  localparam logic [REG_AW-1:0] TMR_PRESCALE   = 8'h04;
  localparam logic [REG_AW-1:0] TMR_MTIME      = 8'h08;
  localparam logic [REG_AW-1:0] TMR_MTIMECMP   = 8'h0C;
  localparam logic [REG_AW-1:0] TMR_INTR_STATE = 8'h10;

  // pwm registers
  localparam logic [REG_AW-1:0] PWM_CTRL   = 8'h00;
  localparam logic [REG_AW-1:0] PWM_PERIOD = 8'h04;
  localparam logic [REG_AW-1:0] PWM_DUTY0  = 8'h08;
  localparam logic [REG_AW-1:0] PWM_DUTY1  = 8'h0C;

  // pwm counter width
  localparam int unsigned PWM_CW = 16;

endpackage

// ==== verilog/periph_xbar.sv ====
module periph_xbar (
  input  logic              clk_i,
  input  logic              rst_i,

  // host port
  input  tlul_pkg::tl_h2d_t tl_h_i,
  output tlul_pkg::tl_d2h_t tl_h_o,

  // device ports
  output tlul_pkg::tl_h2d_t tl_gpio_o,
  input  tlul_pkg::tl_d2h_t tl_gpio_i,
  output tlul_pkg::tl_h2d_t tl_timer_o,
  input  tlul_pkg::tl_d2h_t tl_timer_i,
  output tlul_pkg::tl_h2d_t tl_pwm_o,
  input  tlul_pkg::tl_d2h_t tl_pwm_i
);

  typedef struct packed {
    logic err;
    logic pwm;
    logic timer;
    logic gpio;
  } dev_sel_t;

  dev_sel_t           sel;
  dev_sel_t           sel_q;
  logic               hit_gpio;
  logic               hit_timer;
  logic               hit_pwm;
  logic               bad_op;
  logic               bad_mask;
  logic               busy_q;
  logic               sel_ready;
  logic               host_a_ready;
  logic               a_fire;
  logic               d_fire;
  logic               err_valid_q;
  tlul_pkg::tl_d_op_e err_op_q;
  tlul_pkg::tl_d2h_t  err_rsp;
  tlul_pkg::tl_d2h_t  rsp;

  // window decode on the upper address half
  assign hit_gpio  = (tl_h_i.a_addr & tlul_pkg::DEV_MASK) == tlul_pkg::GPIO_BASE;
  assign hit_timer = (tl_h_i.a_addr & tlul_pkg::DEV_MASK) == tlul_pkg::TIMER_BASE;
  assign hit_pwm   = (tl_h_i.a_addr & tlul_pkg::DEV_MASK) == tlul_pkg::PWM_BASE;

  assign bad_op   = tl_h_i.a_opcode != tlul_pkg::Get &&
                    tl_h_i.a_opcode != tlul_pkg::PutFullData;
  // devices only take full word writes
  assign bad_mask = tl_h_i.a_opcode == tlul_pkg::PutFullData && tl_h_i.a_mask != 4'hF;

  // parallel window select so overlapping bases raise two selects
  always_comb begin
    sel.err   = bad_op || bad_mask || !(hit_gpio || hit_timer || hit_pwm);
    sel.gpio  = hit_gpio  && !bad_op && !bad_mask;
    sel.timer = hit_timer && !bad_op && !bad_mask;
    sel.pwm   = hit_pwm   && !bad_op && !bad_mask;
  end

  assign sel_ready = (sel.gpio  & tl_gpio_i.a_ready)  |
                     (sel.timer & tl_timer_i.a_ready) |
                     (sel.pwm   & tl_pwm_i.a_ready)   |
                     (sel.err   & ~err_valid_q);

  // one access in flight at a time
  assign host_a_ready = !busy_q && sel_ready;
  assign a_fire       = tl_h_i.a_valid && host_a_ready;
  assign d_fire       = tl_h_o.d_valid && tl_h_i.d_ready;

  always_comb begin
    tl_gpio_o          = tl_h_i;
    tl_gpio_o.a_valid  = tl_h_i.a_valid && sel.gpio && !busy_q;
    tl_gpio_o.d_ready  = tl_h_i.d_ready && sel_q.gpio;
    tl_timer_o         = tl_h_i;
    tl_timer_o.a_valid = tl_h_i.a_valid && sel.timer && !busy_q;
    tl_timer_o.d_ready = tl_h_i.d_ready && sel_q.timer;
    tl_pwm_o           = tl_h_i;
    tl_pwm_o.a_valid   = tl_h_i.a_valid && sel.pwm && !busy_q;
    tl_pwm_o.d_ready   = tl_h_i.d_ready && sel_q.pwm;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      sel_q  <= '0;
    end else if (a_fire) begin
      busy_q <= 1'b1;
      sel_q  <= sel;
    end else if (d_fire) begin
      busy_q <= 1'b0;
    end
  end

  // internal error responder
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_valid_q <= 1'b0;
    end else if (a_fire && sel.err) begin
      err_valid_q <= 1'b1;
    end else if (tl_h_i.d_ready) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fire && sel.err) begin
      err_op_q <= (tl_h_i.a_opcode == tlul_pkg::Get) ? tlul_pkg::AccessAckData
                                                     : tlul_pkg::AccessAck;
    end
  end

  assign err_rsp = '{a_ready: 1'b1, d_valid: err_valid_q, d_opcode: err_op_q,
                     d_data: 32'h0, d_error: 1'b1};

  // response back from the recorded target
  always_comb begin
    unique case (1'b1)
      sel_q.gpio:  rsp = tl_gpio_i;
      sel_q.timer: rsp = tl_timer_i;
      sel_q.pwm:   rsp = tl_pwm_i;
      sel_q.err:   rsp = err_rsp;
      default:     rsp = '0;
    endcase
    tl_h_o         = rsp;
    tl_h_o.a_ready = host_a_ready;
  end

  one_dev_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({tl_gpio_o.a_valid, tl_timer_o.a_valid, tl_pwm_o.a_valid}));

  // host keeps the request up until it is taken
  host_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    tl_h_i.a_valid && !host_a_ready |=> tl_h_i.a_valid);

  dev_rsp_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    (tl_gpio_i.d_valid || tl_timer_i.d_valid || tl_pwm_i.d_valid) |-> busy_q);

endmodule

// ==== verilog/gpio.sv ====
module gpio (
  input  logic              clk_i,
  input  logic              rst_i,

  input  tlul_pkg::tl_h2d_t tl_i,
  output tlul_pkg::tl_d2h_t tl_o,

  input  logic [31:0]       gpio_i,
  output logic [31:0]       gpio_o,
  output logic [31:0]       gpio_oe_o,
  output logic              intr_gpio_o
);

  logic [31:0]                 sync1_q;
  logic [31:0]                 data_in_q;
  logic [31:0]                 prev_q;
  logic [31:0]                 data_out_q;
  logic [31:0]                 dir_q;
  logic [31:0]                 intr_state_q;
  logic [31:0]                 intr_enable_q;
  logic [31:0]                 rise;
  logic [31:0]                 intr_clr;
  logic [31:0]                 rdata;
  logic [tlul_pkg::REG_AW-1:0] reg_addr;
  logic                        a_fire;
  logic                        wr_en;
  logic                        rsp_valid_q;
  tlul_pkg::tl_d_op_e          rsp_op_q;
  logic [31:0]                 rsp_data_q;

  assign a_fire   = tl_i.a_valid && !rsp_valid_q;
  assign wr_en    = a_fire && tl_i.a_opcode == tlul_pkg::PutFullData;
  assign reg_addr = tl_i.a_addr[tlul_pkg::REG_AW-1:0];

  // two flop synchronizer, prev_q for edge detect
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q   <= '0;
      data_in_q <= '0;
      prev_q    <= '0;
    end else begin
      sync1_q   <= gpio_i;
      data_in_q <= sync1_q;
      prev_q    <= data_in_q;
    end
  end

  assign rise     = data_in_q & ~prev_q;
  assign intr_clr = (wr_en && reg_addr == tlul_pkg::GPIO_INTR_STATE) ? tl_i.a_data : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_out_q    <= '0;
      dir_q         <= '0;
      intr_state_q  <= '0;
      intr_enable_q <= '0;
    end else begin
      if (wr_en && reg_addr == tlul_pkg::GPIO_DATA_OUT) begin
        data_out_q <= tl_i.a_data;
      end
      if (wr_en && reg_addr == tlul_pkg::GPIO_DIR) begin
        dir_q <= tl_i.a_data;
      end
      if (wr_en && reg_addr == tlul_pkg::GPIO_INTR_ENABLE) begin
        intr_enable_q <= tl_i.a_data;
      end
      // a new edge wins over a clear in the same cycle
      intr_state_q <= (intr_state_q & ~intr_clr) | rise;
    end
  end

  always_comb begin
    case (reg_addr)
      tlul_pkg::GPIO_DATA_IN:     rdata = data_in_q;
      tlul_pkg::GPIO_DATA_OUT:    rdata = data_out_q;
      tlul_pkg::GPIO_DIR:         rdata = dir_q;
      tlul_pkg::GPIO_INTR_STATE:  rdata = intr_state_q;
      tlul_pkg::GPIO_INTR_ENABLE: rdata = intr_enable_q;
      default:                    rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (a_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (tl_i.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      rsp_op_q   <= (tl_i.a_opcode == tlul_pkg::Get) ? tlul_pkg::AccessAckData
                                                     : tlul_pkg::AccessAck;
      rsp_data_q <= (tl_i.a_opcode == tlul_pkg::Get) ? rdata : '0;
    end
  end

  assign tl_o = '{a_ready: !rsp_valid_q, d_valid: rsp_valid_q, d_opcode: rsp_op_q,
                  d_data: rsp_data_q, d_error: 1'b0};

  assign gpio_o      = data_out_q;
  assign gpio_oe_o   = dir_q;
  assign intr_gpio_o = |(intr_state_q & intr_enable_q);

endmodule

// ==== verilog/rv_timer.sv ====
module rv_timer (
  input  logic              clk_i,
  input  logic              rst_i,

  input  tlul_pkg::tl_h2d_t tl_i,
  output tlul_pkg::tl_d2h_t tl_o,

  output logic              intr_timer_o
);

  logic                        ctrl_en_q;
  logic [31:0]                 prescale_q;
  logic [31:0]                 presc_cnt_q;
  logic [31:0]                 mtime_q;
  logic [31:0]                 mtimecmp_q;
  logic                        intr_q;
  logic                        tick;
  logic                        expired;
  logic [31:0]                 rdata;
  logic [tlul_pkg::REG_AW-1:0] reg_addr;
  logic                        a_fire;
  logic                        wr_en;
  logic                        rsp_valid_q;
  tlul_pkg::tl_d_op_e          rsp_op_q;
  logic [31:0]                 rsp_data_q;

  assign a_fire   = tl_i.a_valid && !rsp_valid_q;
  assign wr_en    = a_fire && tl_i.a_opcode == tlul_pkg::PutFullData;
  assign reg_addr = tl_i.a_addr[tlul_pkg::REG_AW-1:0];

  // one mtime step every prescale+1 cycles
  assign tick    = ctrl_en_q && presc_cnt_q == prescale_q;
  // compare only counts while the timer runs
  assign expired = ctrl_en_q && mtime_q >= mtimecmp_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_en_q  <= 1'b0;
      prescale_q <= '0;
      mtimecmp_q <= '0;
    end else begin
      if (wr_en && reg_addr == tlul_pkg::TMR_CTRL) begin
        ctrl_en_q <= tl_i.a_data[0];
      end
      if (wr_en && reg_addr == tlul_pkg::TMR_PRESCALE) begin
        prescale_q <= tl_i.a_data;
      end
      if (wr_en && reg_addr == tlul_pkg::TMR_MTIMECMP) begin
        mtimecmp_q <= tl_i.a_data;
      end
    end
  end

  // restart the prescaler on a new divide value
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      presc_cnt_q <= '0;
    end else if (!ctrl_en_q || tick || (wr_en && reg_addr == tlul_pkg::TMR_PRESCALE)) begin
      presc_cnt_q <= '0;
    end else begin
      presc_cnt_q <= presc_cnt_q + 32'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime_q <= '0;
    end else if (wr_en && reg_addr == tlul_pkg::TMR_MTIME) begin
      mtime_q <= tl_i.a_data;
    end else if (tick) begin
      mtime_q <= mtime_q + 32'd1;
    end
  end

  // clear wins for one cycle, then sets again if still expired
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      intr_q <= 1'b0;
    end else if (wr_en && reg_addr == tlul_pkg::TMR_INTR_STATE && tl_i.a_data[0]) begin
      intr_q <= 1'b0;
    end else if (expired) begin
      intr_q <= 1'b1;
    end
  end

  always_comb begin
    case (reg_addr)
      tlul_pkg::TMR_CTRL:       rdata = {31'h0, ctrl_en_q};
      tlul_pkg::TMR_PRESCALE:   rdata = prescale_q;
      tlul_pkg::TMR_MTIME:      rdata = mtime_q;
      tlul_pkg::TMR_MTIMECMP:   rdata = mtimecmp_q;
      tlul_pkg::TMR_INTR_STATE: rdata = {31'h0, intr_q};
      default:                  rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (a_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (tl_i.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      rsp_op_q   <= (tl_i.a_opcode == tlul_pkg::Get) ? tlul_pkg::AccessAckData
                                                     : tlul_pkg::AccessAck;
      rsp_data_q <= (tl_i.a_opcode == tlul_pkg::Get) ? rdata : '0;
    end
  end

  assign tl_o = '{a_ready: !rsp_valid_q, d_valid: rsp_valid_q, d_opcode: rsp_op_q,
                  d_data: rsp_data_q, d_error: 1'b0};

  assign intr_timer_o = intr_q;

  presc_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    presc_cnt_q <= prescale_q);

endmodule

// ==== verilog/pwm.sv ====
module pwm (
  input  logic              clk_i,
  input  logic              rst_i,

  input  tlul_pkg::tl_h2d_t tl_i,
  output tlul_pkg::tl_d2h_t tl_o,

  output logic [1:0]        pwm_o
);

  logic [1:0]                         ch_en_q;
  logic [tlul_pkg::PWM_CW-1:0]        period_q;
  logic [1:0][tlul_pkg::PWM_CW-1:0]   duty_q;
  logic [tlul_pkg::PWM_CW-1:0]        cnt_q;
  logic                               wrap;
  logic [31:0]                        rdata;
  logic [tlul_pkg::REG_AW-1:0]        reg_addr;
  logic                               a_fire;
  logic                               wr_en;
  logic                               rsp_valid_q;
  tlul_pkg::tl_d_op_e                 rsp_op_q;
  logic [31:0]                        rsp_data_q;

  assign a_fire   = tl_i.a_valid && !rsp_valid_q;
  assign wr_en    = a_fire && tl_i.a_opcode == tlul_pkg::PutFullData;
  assign reg_addr = tl_i.a_addr[tlul_pkg::REG_AW-1:0];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ch_en_q  <= '0;
      period_q <= '0;
      duty_q   <= '0;
    end else if (wr_en) begin
      case (reg_addr)
        tlul_pkg::PWM_CTRL:   ch_en_q   <= tl_i.a_data[1:0];
        tlul_pkg::PWM_PERIOD: period_q  <= tl_i.a_data[tlul_pkg::PWM_CW-1:0];
        tlul_pkg::PWM_DUTY0:  duty_q[0] <= tl_i.a_data[tlul_pkg::PWM_CW-1:0];
        tlul_pkg::PWM_DUTY1:  duty_q[1] <= tl_i.a_data[tlul_pkg::PWM_CW-1:0];
        default: ;
      endcase
    end
  end

  // wrap at period-1, extra bit keeps period 0 and 1 sane
  assign wrap = ({1'b0, cnt_q} + 1'b1) >= {1'b0, period_q};

  always_ff @(posedge clk_i) begin
    if (rst_i || ch_en_q == 2'b00 || wrap) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // high while below duty, so duty above period means always on
  always_comb begin
    for (int n = 0; n < 2; n++) begin
      pwm_o[n] = ch_en_q[n] && cnt_q < duty_q[n];
    end
  end

  always_comb begin
    case (reg_addr)
      tlul_pkg::PWM_CTRL:   rdata = {30'h0, ch_en_q};
      tlul_pkg::PWM_PERIOD: rdata = {{(32 - tlul_pkg::PWM_CW){1'b0}}, period_q};
      tlul_pkg::PWM_DUTY0:  rdata = {{(32 - tlul_pkg::PWM_CW){1'b0}}, duty_q[0]};
      tlul_pkg::PWM_DUTY1:  rdata = {{(32 - tlul_pkg::PWM_CW){1'b0}}, duty_q[1]};
      default:              rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (a_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (tl_i.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      rsp_op_q   <= (tl_i.a_opcode == tlul_pkg::Get) ? tlul_pkg::AccessAckData
                                                     : tlul_pkg::AccessAck;
      rsp_data_q <= (tl_i.a_opcode == tlul_pkg::Get) ? rdata : '0;
    end
  end

  assign tl_o = '{a_ready: !rsp_valid_q, d_valid: rsp_valid_q, d_opcode: rsp_op_q,
                  d_data: rsp_data_q, d_error: 1'b0};

endmodule

// ==== verilog/periph_subsys_top.sv ====
module periph_subsys_top (
  input  logic              clk_i,
  input  logic              rst_i,

  // host port
  input  tlul_pkg::tl_h2d_t tl_i,
  output tlul_pkg::tl_d2h_t tl_o,

  // pads
  input  logic [31:0]       gpio_i,
  output logic [31:0]       gpio_o,
  output logic [31:0]       gpio_oe_o,
  output logic [1:0]        pwm_o,

  // interrupts, left unmerged
  output logic              intr_gpio_o,
  output logic              intr_timer_o
);

  tlul_pkg::tl_h2d_t xbar_to_gpio;
  tlul_pkg::tl_d2h_t gpio_to_xbar;
  tlul_pkg::tl_h2d_t xbar_to_timer;
  tlul_pkg::tl_d2h_t timer_to_xbar;
  tlul_pkg::tl_h2d_t xbar_to_pwm;
  tlul_pkg::tl_d2h_t pwm_to_xbar;

  periph_xbar u_xbar (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .tl_h_i     (tl_i),
    .tl_h_o     (tl_o),
    .tl_gpio_o  (xbar_to_gpio),
    .tl_gpio_i  (gpio_to_xbar),
    .tl_timer_o (xbar_to_timer),
    .tl_timer_i (timer_to_xbar),
    .tl_pwm_o   (xbar_to_pwm),
    .tl_pwm_i   (pwm_to_xbar)
  );

  gpio u_gpio (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .tl_i        (xbar_to_gpio),
    .tl_o        (gpio_to_xbar),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_oe_o   (gpio_oe_o),
    .intr_gpio_o (intr_gpio_o)
  );

  rv_timer u_timer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .tl_i         (xbar_to_timer),
    .tl_o         (timer_to_xbar),
    .intr_timer_o (intr_timer_o)
  );

  pwm u_pwm (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .tl_i  (xbar_to_pwm),
    .tl_o  (pwm_to_xbar),
    .pwm_o (pwm_o)
  );

endmodule

// ==== test/tb_periph_tasks.svh ====
`ifndef TB_PERIPH_TASKS_SVH
`define TB_PERIPH_TASKS_SVH

task automatic wait_a_ready(output logic ok);
  int cycles;
  cycles = 0;
  @(negedge clk);
  while (!dut_tl_o.a_ready && cycles < BUS_TIMEOUT) begin
    @(negedge clk);
    cycles++;
  end
  ok = dut_tl_o.a_ready;
  if (!ok) begin
    $display("timeout at %0t: a_ready stayed low for address %h", $time, host.a_addr);
    timeout_count++;
  end
endtask

// returns at the falling edge where d_valid was seen
task automatic wait_d_valid(output logic ok, output int waited);
  waited = 0;
  @(negedge clk);
  while (!dut_tl_o.d_valid && waited < BUS_TIMEOUT) begin
    @(negedge clk);
    waited++;
  end
  ok = dut_tl_o.d_valid;
  if (!ok) begin
    $display("timeout at %0t: no response for address %h", $time, host.a_addr);
    timeout_count++;
  end
endtask

task automatic tl_access(input logic is_write, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [3:0] mask,
                         output logic [31:0] rdata, output logic err);
  logic ok;
  int   waited;
  tlul_pkg::tl_d_op_e exp_op;
  exp_op        = is_write ? tlul_pkg::AccessAck : tlul_pkg::AccessAckData;
  rdata         = '0;
  err           = 1'b1;
  host.a_valid  = 1'b1;
  host.a_opcode = is_write ? tlul_pkg::PutFullData : tlul_pkg::Get;
  host.a_addr   = addr;
  host.a_data   = is_write ? wdata : 32'h0;
  host.a_mask   = mask;
  host.d_ready  = 1'b1;
  wait_a_ready(ok);
  if (!ok) begin
    host.a_valid = 1'b0;
    return;
  end
  @(posedge clk);
  #0.5;
  accept_cycle = cycle_count;
  host.a_valid = 1'b0;
  wait_d_valid(ok, waited);
  if (!ok) begin
    return;
  end
  // response is due one cycle after acceptance
  compare_word("d_valid latency", 32'd0, waited);
  compare_word("d_opcode", {29'h0, exp_op}, {29'h0, dut_tl_o.d_opcode});
  rdata = dut_tl_o.d_data;
  err   = dut_tl_o.d_error;
  @(posedge clk);
  #0.5;
endtask

task automatic tl_write(input logic [31:0] addr, input logic [31:0] data,
                        input logic [3:0] mask, output logic err);
  logic [31:0] unused;
  tl_access(1'b1, addr, data, mask, unused, err);
endtask

task automatic tl_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
  tl_access(1'b0, addr, 32'h0, 4'hF, data, err);
endtask

task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
  logic err;
  tl_write(addr, data, 4'hF, err);
  compare_bit($sformatf("d_error on write to %h", addr), 1'b0, err);
endtask

task automatic expect_read(input logic [31:0] addr, input logic [31:0] exp, input string name);
  logic [31:0] data;
  logic        err;
  tl_read(addr, data, err);
  compare_bit({name, " d_error"}, 1'b0, err);
  compare_word(name, exp, data);
endtask

task automatic check_reset_values();
  compare_word("gpio_oe_o", 32'h0, gpio_oe);
  compare_word("gpio_o", 32'h0, gpio_out);
  compare_word("pwm_o", 32'h0, {30'h0, pwm_out});
  compare_bit("intr_gpio_o", 1'b0, intr_gpio);
  compare_bit("intr_timer_o", 1'b0, intr_timer);
  expect_read(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DATA_IN), gpio_in, "gpio data_in");
  // register offsets are consecutive words in each window
  for (int off = 4; off <= 16; off += 4) begin
    expect_read(tlul_pkg::GPIO_BASE | 32'(off), 32'h0, $sformatf("gpio reg %h", off));
  end
  for (int off = 0; off <= 16; off += 4) begin
    expect_read(tlul_pkg::TIMER_BASE | 32'(off), 32'h0, $sformatf("timer reg %h", off));
  end
  for (int off = 0; off <= 12; off += 4) begin
    expect_read(tlul_pkg::PWM_BASE | 32'(off), 32'h0, $sformatf("pwm reg %h", off));
  end
endtask

task automatic gpio_io_and_irq();
  logic [31:0] w;
  logic [31:0] data;
  logic        err;
  int          polls;
  w = rand_bits(32);
  write_reg(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DATA_OUT), w);
  compare_word("gpio_o", w, gpio_out);
  expect_read(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DATA_OUT), w, "gpio data_out");
  w = rand_bits(32);
  write_reg(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DIR), w);
  compare_word("gpio_oe_o", w, gpio_oe);
  expect_read(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DIR), w, "gpio dir");

  // input goes through the synchronizer, so poll
  gpio_in = rand_bits(32);
  polls   = 0;
  tl_read(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DATA_IN), data, err);
  while (data !== gpio_in && polls < POLL_TIMEOUT) begin
    tl_read(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DATA_IN), data, err);
    polls++;
  end
  compare_bit("gpio data_in d_error", 1'b0, err);
  compare_word("gpio data_in", gpio_in, data);

  gpio_in = '0;
  wait_cycles(4);
  write_reg(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_INTR_STATE), 32'hFFFF_FFFF);
  write_reg(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_INTR_ENABLE), 32'h0000_0020);
  compare_bit("intr_gpio_o", 1'b0, intr_gpio);
  gpio_in[5] = 1'b1;
  polls = 0;
  @(negedge clk);
  while (!intr_gpio && polls < INTR_TIMEOUT) begin
    @(negedge clk);
    polls++;
  end
  if (!intr_gpio) begin
    $display("timeout at %0t: intr_gpio_o did not rise after an edge on pin 5", $time);
    timeout_count++;
  end
  wait_cycles(1);
  expect_read(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_INTR_STATE), 32'h20,
              "gpio intr_state");
  write_reg(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_INTR_STATE), 32'h20);
  compare_bit("intr_gpio_o", 1'b0, intr_gpio);
  expect_read(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_INTR_STATE), 32'h0,
              "gpio intr_state");
  write_reg(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_INTR_ENABLE), 32'h0);
  gpio_in = '0;
endtask

task automatic timer_rate_and_irq();
  logic [31:0] p;
  logic [31:0] t0;
  logic [31:0] t1;
  logic        err;
  int          c0;
  int          exp_delta;
  int          act_delta;
  int          polls;
  p = rand_bits(2) + 32'd1;
  write_reg(reg_address(tlul_pkg::TIMER_BASE, tlul_pkg::TMR_PRESCALE), p);
  // keep the compare out of reach while measuring
  write_reg(reg_address(tlul_pkg::TIMER_BASE, tlul_pkg::TMR_MTIMECMP), 32'hFFFF_FFFF);
  write_reg(reg_address(tlul_pkg::TIMER_BASE, tlul_pkg::TMR_CTRL), 32'h1);
  tl_read(reg_address(tlul_pkg::TIMER_BASE, tlul_pkg::TMR_MTIME), t0, err);
  compare_bit("mtime d_error", 1'b0, err);
  c0 = accept_cycle;
  wait_cycles(60);
  tl_read(reg_address(tlul_pkg::TIMER_BASE, tlul_pkg::TMR_MTIME), t1, err);
  compare_bit("mtime d_error", 1'b0, err);
  exp_delta = (accept_cycle - c0) / (int'(p) + 1);
  act_delta = int'(t1 - t0);
  if (act_delta > exp_delta + 1 || act_delta + 1 < exp_delta) begin
    $display("[FAIL] t=%0t mtime delta expected %0d actual %0d", $time, exp_delta, act_delta);
    error_count++;
  end

  tl_read(reg_address(tlul_pkg::TIMER_BASE, tlul_pkg::TMR_MTIME), t0, err);
  compare_bit("mtime d_error", 1'b0, err);
  write_reg(reg_address(tlul_pkg::TIMER_BASE, tlul_pkg::TMR_MTIMECMP), t0 + 32'd6);
  compare_bit("intr_timer_o", 1'b0, intr_timer);
  polls = 0;
  @(negedge clk);
  while (!intr_timer && polls < INTR_TIMEOUT) begin
    @(negedge clk);
    polls++;
  end
  if (!intr_timer) begin
    $display("timeout at %0t: intr_timer_o did not rise after mtime passed mtimecmp", $time);
    timeout_count++;
  end
  wait_cycles(1);
  expect_read(reg_address(tlul_pkg::TIMER_BASE, tlul_pkg::TMR_INTR_STATE), 32'h1,
              "timer intr_state");

  write_reg(reg_address(tlul_pkg::TIMER_BASE, tlul_pkg::TMR_CTRL), 32'h0);
  write_reg(reg_address(tlul_pkg::TIMER_BASE, tlul_pkg::TMR_MTIME), 32'h0);
  write_reg(reg_address(tlul_pkg::TIMER_BASE, tlul_pkg::TMR_INTR_STATE), 32'h1);
  wait_cycles(2);
  compare_bit("intr_timer_o", 1'b0, intr_timer);
  expect_read(reg_address(tlul_pkg::TIMER_BASE, tlul_pkg::TMR_INTR_STATE), 32'h0,
              "timer intr_state");
endtask

// any window of whole periods holds duty high cycles per period
task automatic count_high(input int n, output int h0, output int h1);
  h0 = 0;
  h1 = 0;
  repeat (n) begin
    @(negedge clk);
    if (pwm_out[0]) h0++;
    if (pwm_out[1]) h1++;
  end
  @(posedge clk);
  #0.5;
endtask

task automatic pwm_duty_count();
  int per;
  int d0;
  int d1;
  int h0;
  int h1;
  int nper;
  nper = 5;
  per  = 8 + int'(rand_bits(3));
  d0   = int'(rand_bits(3));
  d1   = per + 3;
  write_reg(reg_address(tlul_pkg::PWM_BASE, tlul_pkg::PWM_PERIOD), 32'(per));
  write_reg(reg_address(tlul_pkg::PWM_BASE, tlul_pkg::PWM_DUTY0), 32'(d0));
  write_reg(reg_address(tlul_pkg::PWM_BASE, tlul_pkg::PWM_DUTY1), 32'(d1));
  write_reg(reg_address(tlul_pkg::PWM_BASE, tlul_pkg::PWM_CTRL), 32'h3);
  count_high(nper * per, h0, h1);
  compare_word("pwm_o[0] high cycles", 32'(nper * d0), 32'(h0));
  compare_word("pwm_o[1] high cycles", 32'(nper * ((d1 > per) ? per : d1)), 32'(h1));

  write_reg(reg_address(tlul_pkg::PWM_BASE, tlul_pkg::PWM_CTRL), 32'h1);
  count_high(nper * per, h0, h1);
  compare_word("pwm_o[0] high cycles", 32'(nper * d0), 32'(h0));
  compare_word("pwm_o[1] high cycles", 32'h0, 32'(h1));
  write_reg(reg_address(tlul_pkg::PWM_BASE, tlul_pkg::PWM_CTRL), 32'h0);
  compare_word("pwm_o", 32'h0, {30'h0, pwm_out});
endtask

task automatic error_responses();
  logic [31:0] data;
  logic        err;
  tl_read(32'h4005_0010, data, err);
  compare_bit("unmapped read d_error", 1'b1, err);
  compare_word("unmapped read d_data", 32'h0, data);

  write_reg(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DIR), 32'h1234_5678);
  tl_write(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DIR), 32'hEDCB_A987, 4'h3, err);
  compare_bit("partial mask write d_error", 1'b1, err);
  // legal read, so no error expected here
  expect_read(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DIR), 32'h1234_5678,
              "gpio dir after partial write");
endtask

task automatic d_channel_stall();
  logic [31:0] held;
  logic        ok;
  int          waited;
  write_reg(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DIR), 32'h5A5A_0FF0);
  host.a_valid  = 1'b1;
  host.a_opcode = tlul_pkg::Get;
  host.a_addr   = reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DIR);
  host.a_data   = 32'h0;
  host.a_mask   = 4'hF;
  host.d_ready  = 1'b0;
  wait_a_ready(ok);
  if (!ok) begin
    host.a_valid = 1'b0;
    host.d_ready = 1'b1;
    return;
  end
  @(posedge clk);
  #0.5;
  host.a_valid = 1'b0;
  wait_d_valid(ok, waited);
  if (!ok) begin
    host.d_ready = 1'b1;
    return;
  end
  held = dut_tl_o.d_data;
  compare_word("stalled d_data", 32'h5A5A_0FF0, held);
  repeat (6) begin
    @(negedge clk);
    compare_bit("stalled d_valid", 1'b1, dut_tl_o.d_valid);
    compare_word("stalled d_data", held, dut_tl_o.d_data);
    compare_bit("stalled a_ready", 1'b0, dut_tl_o.a_ready);
  end
  @(posedge clk);
  #0.5;
  host.d_ready = 1'b1;
  wait_cycles(1);
  expect_read(reg_address(tlul_pkg::GPIO_BASE, tlul_pkg::GPIO_DIR), 32'h5A5A_0FF0,
              "gpio dir after stall");
endtask

`endif

// ==== test/tb_periph_subsys.sv ====
module tb_periph_subsys;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BUS_TIMEOUT  = 50;
  localparam int POLL_TIMEOUT = 100;
  localparam int INTR_TIMEOUT = 300;
  localparam logic [31:0] LFSR_SEED = 32'h9a47_65c3;

  logic              clk;
  logic              rst;
  tlul_pkg::tl_h2d_t host;
  tlul_pkg::tl_d2h_t dut_tl_o;
  logic [31:0]       gpio_in;
  logic [31:0]       gpio_out;
  logic [31:0]       gpio_oe;
  logic [1:0]        pwm_out;
  logic              intr_gpio;
  logic              intr_timer;

  logic [31:0]       lfsr_state;
  int                error_count;
  int                timeout_count;
  int                cycle_count;
  // cycle number of the last accepted A beat
  int                accept_cycle;

  periph_subsys_top dut (
    .clk_i        (clk),
    .rst_i        (rst),
    .tl_i         (host),
    .tl_o         (dut_tl_o),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_oe_o    (gpio_oe),
    .pwm_o        (pwm_out),
    .intr_gpio_o  (intr_gpio),
    .intr_timer_o (intr_timer)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic logic [31:0] reg_address(input logic [31:0] base,
                                              input logic [tlul_pkg::REG_AW-1:0] off);
    return base | {24'h0, off};
  endfunction

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp, act);
      error_count++;
    end
  endtask

  // leaves the caller just after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #0.5;
  endtask

  `include "tb_periph_tasks.svh"

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    host          = '0;
    host.d_ready  = 1'b1;
    gpio_in       = '0;
    lfsr_state    = LFSR_SEED;
    error_count   = 0;
    timeout_count = 0;
    cycle_count   = 0;
    accept_cycle  = 0;

    repeat (16) @(posedge clk);
    #0.5;
    rst = 1'b0;
    wait_cycles(2);

    check_reset_values();
    gpio_io_and_irq();
    timer_rate_and_irq();
    pwm_duty_count();
    error_responses();
    d_channel_stall();

    $display("failed checks: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+test
verilog/tlul_pkg.sv
verilog/periph_xbar.sv
verilog/gpio.sv
verilog/rv_timer.sv
verilog/pwm.sv
verilog/periph_subsys_top.sv
test/tb_periph_subsys.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = tb_periph_subsys
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

lint:
	$(TOOL) --lint-only -Wall --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
